//--- Makefile
# Verilator simulation of the offload subsystem

VERILATOR ?= verilator
TOP       ?= tb_xif_offload
FILELIST  ?= xif_offload.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_xif_offload.sv
// testbench for the offload top with file stimulus, reference model, LFSR gaps and watchdog
`timescale 1ns/1ps

module tb_xif_offload;

  localparam int LATENCY      = xif_pkg::XIF_LATENCY_DEF;
  localparam int MAX_INFLIGHT = xif_pkg::XIF_MAX_INFLIGHT_DEF;
  localparam int MAX_LINES    = 64;

  logic                           clk;
  logic                           rst_n;
  logic                           instr_valid;
  xif_pkg::xif_op_e               instr_op;
  logic [xif_pkg::XIF_REG_W-1:0]  instr_rd, instr_rs1, instr_rs2;
  logic [xif_pkg::XIF_IMM_W-1:0]  instr_imm;
  logic                           stall, illegal, issue_fire, result_valid;
  logic [xif_pkg::XIF_ID_W-1:0]   issue_id, result_id;
  logic [xif_pkg::XIF_REG_W-1:0]  result_rd;
  logic [xif_pkg::XIF_DATA_W-1:0] result_data;

  // program as read from the data file
  logic [2:0]                     op_a  [MAX_LINES];
  logic [xif_pkg::XIF_REG_W-1:0]  rd_a  [MAX_LINES];
  logic [xif_pkg::XIF_REG_W-1:0]  rs1_a [MAX_LINES];
  logic [xif_pkg::XIF_REG_W-1:0]  rs2_a [MAX_LINES];
  logic [xif_pkg::XIF_IMM_W-1:0]  imm_a [MAX_LINES];
  logic                           ill_a [MAX_LINES];
  int                             n_instr;
  logic                           loaded;

  // reference model state and expected results in issue order
  logic [xif_pkg::XIF_DATA_W-1:0] model_regs [32];
  logic [xif_pkg::XIF_ID_W-1:0]   exp_id;
  logic [xif_pkg::XIF_ID_W-1:0]   exp_id_q   [$];
  logic [xif_pkg::XIF_REG_W-1:0]  exp_rd_q   [$];
  logic [xif_pkg::XIF_DATA_W-1:0] exp_data_q [$];
  logic [31:0]                    lfsr;

  xif_offload_top #(
    .COPROC_LATENCY (LATENCY),
    .MAX_INFLIGHT   (MAX_INFLIGHT)
  ) dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_op_i     (instr_op),
    .instr_rd_i     (instr_rd),
    .instr_rs1_i    (instr_rs1),
    .instr_rs2_i    (instr_rs2),
    .instr_imm_i    (instr_imm),
    .stall_o        (stall),
    .illegal_o      (illegal),
    .issue_id_o     (issue_id),
    .issue_fire_o   (issue_fire),
    .result_valid_o (result_valid),
    .result_id_o    (result_id),
    .result_rd_o    (result_rd),
    .result_data_o  (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      stop_failed();
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // two bits, 0 to 3 idle cycles
  task automatic draw_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
  endtask

  // li zero-extends, sll uses the low 5 bits of rs2
  function automatic logic [31:0] model_result(input logic [2:0] op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [15:0] imm);
    case (op)
      3'd0:    return {16'h0000, imm};
      3'd1:    return a + b;
      3'd2:    return a - b;
      3'd3:    return a ^ b;
      default: return a << b[4:0];
    endcase
  endfunction

  task automatic load_program();
    int    fd;
    int    code;
    int    f_op, f_rd, f_rs1, f_rs2, f_imm, f_ill;
    string line;
    n_instr = 0;
    fd = $fopen("sim/xif_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/xif_testdata.txt");
      stop_failed();
    end else begin
      while (!$feof(fd) && n_instr < MAX_LINES) begin
        code = $fgets(line, fd);
        // header lines start with a hash
        if (code > 0 && line.getc(0) != "#") begin
          code = $sscanf(line, "%h %h %h %h %h %h", f_op, f_rd, f_rs1, f_rs2, f_imm, f_ill);
          if (code == 6) begin
            op_a[n_instr]  = f_op[2:0];
            rd_a[n_instr]  = f_rd[4:0];
            rs1_a[n_instr] = f_rs1[4:0];
            rs2_a[n_instr] = f_rs2[4:0];
            imm_a[n_instr] = f_imm[15:0];
            ill_a[n_instr] = f_ill[0];
            n_instr++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // called in the cycle whose rising edge takes the instruction
  task automatic accept_instr(input int i);
    logic [31:0] res;
    compare_value("issue_fire_o", 32'(issue_fire), 32'd1);
    compare_value("issue_id_o", 32'(issue_id), 32'(exp_id));
    compare_value("illegal_o", 32'(illegal), 32'(ill_a[i]));
    if (op_a[i] <= 3'd4 && rd_a[i] != '0) begin
      res = model_result(op_a[i], model_regs[rs1_a[i]], model_regs[rs2_a[i]], imm_a[i]);
      model_regs[rd_a[i]] = res;
      exp_id_q.push_back(exp_id);
      exp_rd_q.push_back(rd_a[i]);
      exp_data_q.push_back(res);
    end
    exp_id = exp_id + 4'd1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int                            gap;
    logic                          raw;
    logic                          saw_stall;
    logic [xif_pkg::XIF_REG_W-1:0] prev_wb_rd;
    instr_valid = 1'b0;
    instr_op    = xif_pkg::OP_LI;
    instr_rd    = '0;
    instr_rs1   = '0;
    instr_rs2   = '0;
    instr_imm   = '0;
    rst_n       = 1'b0;
    loaded      = 1'b0;
    lfsr        = 32'hde514a81;
    exp_id      = '0;
    prev_wb_rd  = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    load_program();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_instr; i++) begin
      @(negedge clk);
      instr_valid = 1'b0;
      // reads the previous result straight away, no idle gap
      raw = (prev_wb_rd != '0) && (rs1_a[i] == prev_wb_rd || rs2_a[i] == prev_wb_rd);
      if (!raw) begin
        draw_gap(gap);
        repeat (gap) @(negedge clk);
      end
      instr_valid = 1'b1;
      instr_op    = xif_pkg::xif_op_e'(op_a[i]);
      instr_rd    = rd_a[i];
      instr_rs1   = rs1_a[i];
      instr_rs2   = rs2_a[i];
      instr_imm   = imm_a[i];
      saw_stall   = 1'b0;
      // sample mid low phase, inputs held while stalled
      #1;
      while (stall) begin
        saw_stall = 1'b1;
        @(negedge clk);
        #1;
      end
      accept_instr(i);
      if (raw && LATENCY > 1) begin
        compare_value("stall_o seen", 32'(saw_stall), 32'd1);
      end
      prev_wb_rd = (op_a[i] <= 3'd4) ? rd_a[i] : '0;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    while (exp_data_q.size() != 0) @(negedge clk);
    // room for a stray result to show up
    repeat (LATENCY + 2) @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // result monitor and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : monitor
    forever begin
      @(negedge clk);
      if (rst_n && result_valid === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          $display("a result for rd %0d came back with no instruction outstanding", result_rd);
          stop_failed();
        end else begin
          compare_value("result_id_o", 32'(result_id), 32'(exp_id_q.pop_front()));
          compare_value("result_rd_o", 32'(result_rd), 32'(exp_rd_q.pop_front()));
          compare_value("result_data_o", result_data, exp_data_q.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_instr * (LATENCY + 8) + 100) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles",
             n_instr * (LATENCY + 8) + 100);
    stop_failed();
  end

endmodule

//--- sim/xif_testdata.txt
# columns: op rd rs1 rs2 imm illegal, all hex
# op 0 li, 1 add, 2 sub, 3 xor, 4 sll, 5 to 7 unassigned
0 01 00 00 1234 0
0 02 00 00 ffff 0
0 03 00 00 0004 0
1 04 01 02 0000 0
2 05 04 01 0000 0
3 06 05 02 0000 0
4 07 01 03 0000 0
5 08 01 02 0000 1
1 00 01 02 0000 0
1 09 00 01 0000 0
6 0a 01 01 0000 1
4 0b 02 04 0000 0
2 0c 00 02 0000 0
0 01 00 00 8000 0
4 0d 01 03 0000 0
7 0e 00 00 0000 1
3 0f 0d 0c 0000 0
1 10 0f 09 0000 0
0 00 00 00 abcd 0
1 11 00 00 0000 0

//--- source/xif_coproc.sv
// coprocessor with opcode decode, accept/reject and a fixed-latency result pipeline
`timescale 1ns/1ps

module xif_coproc #(
  parameter int COPROC_LATENCY = xif_pkg::XIF_LATENCY_DEF,
  parameter int MAX_INFLIGHT   = xif_pkg::XIF_MAX_INFLIGHT_DEF
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // issue channel
  input  logic                           issue_valid_i,
  input  logic [xif_pkg::XIF_ID_W-1:0]   issue_id_i,
  input  xif_pkg::xif_op_e               issue_op_i,
  input  logic [xif_pkg::XIF_REG_W-1:0]  issue_rd_i,
  input  logic [xif_pkg::XIF_DATA_W-1:0] issue_rs1_data_i,
  input  logic [xif_pkg::XIF_DATA_W-1:0] issue_rs2_data_i,
  input  logic [xif_pkg::XIF_IMM_W-1:0]  issue_imm_i,
  output logic                           issue_ready_o,
  output logic                           issue_accept_o,
  output logic                           issue_writeback_o,
  // result channel, no back-pressure
  output logic                           result_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0]   result_id_o,
  output logic [xif_pkg::XIF_REG_W-1:0]  result_rd_o,
  output logic [xif_pkg::XIF_DATA_W-1:0] result_data_o
);

  localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);
  localparam int PAD_W = xif_pkg::XIF_DATA_W - xif_pkg::XIF_IMM_W;

  logic [xif_pkg::XIF_DATA_W-1:0] alu_result;
  logic                           enter;
  logic [CNT_W-1:0]               inflight_q, inflight_d;

  // pipeline stages, last one drives the result channel
  logic [COPROC_LATENCY-1:0]      valid_q;
  logic [xif_pkg::XIF_ID_W-1:0]   id_q   [COPROC_LATENCY];
  logic [xif_pkg::XIF_REG_W-1:0]  rd_q   [COPROC_LATENCY];
  logic [xif_pkg::XIF_DATA_W-1:0] data_q [COPROC_LATENCY];

  //////////////////////////////////////////////////////////////////////
  // decode and execute at issue
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    issue_accept_o = 1'b1;
    alu_result     = '0;
    case (issue_op_i)
      xif_pkg::OP_LI:  alu_result = {{PAD_W{1'b0}}, issue_imm_i};
      xif_pkg::OP_ADD: alu_result = issue_rs1_data_i + issue_rs2_data_i;
      xif_pkg::OP_SUB: alu_result = issue_rs1_data_i - issue_rs2_data_i;
      xif_pkg::OP_XOR: alu_result = issue_rs1_data_i ^ issue_rs2_data_i;
      xif_pkg::OP_SLL: alu_result = issue_rs1_data_i << issue_rs2_data_i[4:0];
      default:         issue_accept_o = 1'b0;
    endcase
  end

  // rd 0 is accepted but never written
  assign issue_writeback_o = issue_accept_o & (issue_rd_i != '0);
  assign enter = issue_valid_i & issue_ready_o & issue_writeback_o;

  // full unless a result leaves this cycle
  assign issue_ready_o = (inflight_q != CNT_W'(MAX_INFLIGHT)) | result_valid_o;

  always_comb begin
    inflight_d = inflight_q;
    if (enter && !result_valid_o) begin
      inflight_d = inflight_q + 1'b1;
    end else if (!enter && result_valid_o) begin
      inflight_d = inflight_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // latency pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      inflight_q <= '0;
    end else begin
      valid_q[0] <= enter;
      for (int i = 1; i < COPROC_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
      inflight_q <= inflight_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q[0]   <= issue_id_i;
    rd_q[0]   <= issue_rd_i;
    data_q[0] <= alu_result;
    for (int i = 1; i < COPROC_LATENCY; i++) begin
      id_q[i]   <= id_q[i-1];
      rd_q[i]   <= rd_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  assign result_valid_o = valid_q[COPROC_LATENCY-1];
  assign result_id_o    = id_q[COPROC_LATENCY-1];
  assign result_rd_o    = rd_q[COPROC_LATENCY-1];
  assign result_data_o  = data_q[COPROC_LATENCY-1];

  a_inflight_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inflight_q <= CNT_W'(MAX_INFLIGHT));

endmodule

//--- source/xif_dispatcher.sv
// issue dispatcher with id counter, stall and illegal reporting
`timescale 1ns/1ps

module xif_dispatcher (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // instruction from the core side
  input  logic                          instr_valid_i,
  input  xif_pkg::xif_op_e              instr_op_i,
  input  logic [xif_pkg::XIF_REG_W-1:0] instr_rd_i,
  input  logic [xif_pkg::XIF_IMM_W-1:0] instr_imm_i,
  input  logic                          hazard_i,
  // issue channel
  input  logic                          issue_ready_i,
  input  logic                          issue_accept_i,
  input  logic                          issue_writeback_i,
  output logic                          issue_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0]  issue_id_o,
  output xif_pkg::xif_op_e              issue_op_o,
  output logic [xif_pkg::XIF_REG_W-1:0] issue_rd_o,
  output logic [xif_pkg::XIF_IMM_W-1:0] issue_imm_o,
  // scoreboard set port
  output logic                          sb_set_o,
  output logic [xif_pkg::XIF_REG_W-1:0] sb_set_rd_o,
  // status
  output logic                          stall_o,
  output logic                          illegal_o
);

  logic [xif_pkg::XIF_ID_W-1:0] id_q, id_d;
  logic                         issue_fire;

  //////////////////////////////////////////////////////////////////////
  // issue channel
  //////////////////////////////////////////////////////////////////////

  // offer only hazard-free instructions
  assign issue_valid_o = instr_valid_i & ~hazard_i;
  assign issue_fire    = issue_valid_o & issue_ready_i;
  assign issue_id_o    = id_q;
  assign issue_op_o    = instr_op_i;
  assign issue_rd_o    = instr_rd_i;
  assign issue_imm_o   = instr_imm_i;

  // transfer and acceptance share one edge
  assign stall_o = instr_valid_i & ~issue_fire;

  // pending bit for writeback transfers only
  assign sb_set_o    = issue_fire & issue_writeback_i;
  assign sb_set_rd_o = instr_rd_i;

  // rejected in its transfer cycle
  assign illegal_o = issue_fire & ~issue_accept_i;

  //////////////////////////////////////////////////////////////////////
  // issue id
  //////////////////////////////////////////////////////////////////////

  // wraps at 16
  always_comb begin
    id_d = id_q;
    if (issue_fire) begin
      id_d = id_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else begin
      id_q <= id_d;
    end
  end

  // core holds the instruction steady while it waits
  a_hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_o |=> instr_valid_i && $stable(instr_op_i) && $stable(instr_rd_i)
                && $stable(instr_imm_i));

endmodule

//--- source/xif_offload_top.sv
// offload subsystem top with dispatcher, scoreboard, coprocessor and register file
`timescale 1ns/1ps

module xif_offload_top #(
  parameter int COPROC_LATENCY = xif_pkg::XIF_LATENCY_DEF,
  parameter int MAX_INFLIGHT   = xif_pkg::XIF_MAX_INFLIGHT_DEF
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           instr_valid_i,
  input  xif_pkg::xif_op_e               instr_op_i,
  input  logic [xif_pkg::XIF_REG_W-1:0]  instr_rd_i,
  input  logic [xif_pkg::XIF_REG_W-1:0]  instr_rs1_i,
  input  logic [xif_pkg::XIF_REG_W-1:0]  instr_rs2_i,
  input  logic [xif_pkg::XIF_IMM_W-1:0]  instr_imm_i,
  output logic                           stall_o,
  output logic                           illegal_o,
  output logic [xif_pkg::XIF_ID_W-1:0]   issue_id_o,
  output logic                           issue_fire_o,
  output logic                           result_valid_o,
  output logic [xif_pkg::XIF_ID_W-1:0]   result_id_o,
  output logic [xif_pkg::XIF_REG_W-1:0]  result_rd_o,
  output logic [xif_pkg::XIF_DATA_W-1:0] result_data_o
);

  // issue channel
  logic                           issue_valid;
  logic                           issue_ready;
  logic                           issue_accept;
  logic                           issue_writeback;
  xif_pkg::xif_op_e               issue_op;
  logic [xif_pkg::XIF_REG_W-1:0]  issue_rd;
  logic [xif_pkg::XIF_IMM_W-1:0]  issue_imm;
  logic [xif_pkg::XIF_DATA_W-1:0] rs1_data;
  logic [xif_pkg::XIF_DATA_W-1:0] rs2_data;
  // scoreboard
  logic                           hazard;
  logic                           sb_set;
  logic [xif_pkg::XIF_REG_W-1:0]  sb_set_rd;

  assign issue_fire_o = issue_valid & issue_ready;

  //////////////////////////////////////////////////////////////////////
  // core side
  //////////////////////////////////////////////////////////////////////

  xif_dispatcher u_dispatcher (
    .clk_i,
    .rst_ni,
    .instr_valid_i,
    .instr_op_i,
    .instr_rd_i,
    .instr_imm_i,
    .hazard_i          (hazard),
    .issue_ready_i     (issue_ready),
    .issue_accept_i    (issue_accept),
    .issue_writeback_i (issue_writeback),
    .issue_valid_o     (issue_valid),
    .issue_id_o,
    .issue_op_o        (issue_op),
    .issue_rd_o        (issue_rd),
    .issue_imm_o       (issue_imm),
    .sb_set_o          (sb_set),
    .sb_set_rd_o       (sb_set_rd),
    .stall_o,
    .illegal_o
  );

  // results free the pending bits
  xif_scoreboard u_scoreboard (
    .clk_i,
    .rst_ni,
    .rs1_i    (instr_rs1_i),
    .rs2_i    (instr_rs2_i),
    .set_i    (sb_set),
    .set_rd_i (sb_set_rd),
    .clr_i    (result_valid_o),
    .clr_rd_i (result_rd_o),
    .hazard_o (hazard)
  );

  // operands read straight from the instruction's sources
  xif_regfile u_regfile (
    .clk_i,
    .rst_ni,
    .raddr1_i (instr_rs1_i),
    .raddr2_i (instr_rs2_i),
    .we_i     (result_valid_o),
    .waddr_i  (result_rd_o),
    .wdata_i  (result_data_o),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  //////////////////////////////////////////////////////////////////////
  // coprocessor
  //////////////////////////////////////////////////////////////////////

  xif_coproc #(
    .COPROC_LATENCY (COPROC_LATENCY),
    .MAX_INFLIGHT   (MAX_INFLIGHT)
  ) u_coproc (
    .clk_i,
    .rst_ni,
    .issue_valid_i     (issue_valid),
    .issue_id_i        (issue_id_o),
    .issue_op_i        (issue_op),
    .issue_rd_i        (issue_rd),
    .issue_rs1_data_i  (rs1_data),
    .issue_rs2_data_i  (rs2_data),
    .issue_imm_i       (issue_imm),
    .issue_ready_o     (issue_ready),
    .issue_accept_o    (issue_accept),
    .issue_writeback_o (issue_writeback),
    .result_valid_o,
    .result_id_o,
    .result_rd_o,
    .result_data_o
  );

endmodule

//--- source/xif_pkg.sv
// opcode enum, datapath widths and default parameters for the offload subsystem

package xif_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////

  // issue id, wraps at 16
  localparam int XIF_ID_W   = 4;
  localparam int XIF_REG_W  = 5;
  localparam int XIF_DATA_W = 32;
  // li zero-extends this
  localparam int XIF_IMM_W  = 16;

  // defaults for the top level parameters
  localparam int XIF_LATENCY_DEF      = 3;
  localparam int XIF_MAX_INFLIGHT_DEF = 2;

  ////////////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////////////

  // 5 to 7 unassigned, coprocessor rejects them
  typedef enum logic [2:0] {
    OP_LI  = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_XOR = 3'd3,
    OP_SLL = 3'd4
  } xif_op_e;

endpackage

//--- source/xif_regfile.sv
// 32x32 register file, two read ports with write bypass, register 0 fixed to zero
`timescale 1ns/1ps

module xif_regfile (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [xif_pkg::XIF_REG_W-1:0]  raddr1_i,
  input  logic [xif_pkg::XIF_REG_W-1:0]  raddr2_i,
  input  logic                           we_i,
  input  logic [xif_pkg::XIF_REG_W-1:0]  waddr_i,
  input  logic [xif_pkg::XIF_DATA_W-1:0] wdata_i,
  output logic [xif_pkg::XIF_DATA_W-1:0] rdata1_o,
  output logic [xif_pkg::XIF_DATA_W-1:0] rdata2_o
);

  localparam int NREGS = 2 ** xif_pkg::XIF_REG_W;

  logic [xif_pkg::XIF_DATA_W-1:0] regs_q [NREGS];
  logic                           wr_en;

  // writes to x0 dropped
  assign wr_en = we_i & (waddr_i != '0);

  // same-cycle write shows up on a matching read
  assign rdata1_o = (wr_en && (waddr_i == raddr1_i)) ? wdata_i : regs_q[raddr1_i];
  assign rdata2_o = (wr_en && (waddr_i == raddr2_i)) ? wdata_i : regs_q[raddr2_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- source/xif_scoreboard.sv
// register scoreboard with pending-write bits and hazard lookup
`timescale 1ns/1ps

module xif_scoreboard (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [xif_pkg::XIF_REG_W-1:0] rs1_i,
  input  logic [xif_pkg::XIF_REG_W-1:0] rs2_i,
  input  logic                          set_i,
  input  logic [xif_pkg::XIF_REG_W-1:0] set_rd_i,
  input  logic                          clr_i,
  input  logic [xif_pkg::XIF_REG_W-1:0] clr_rd_i,
  output logic                          hazard_o
);

  localparam int NREGS = 2 ** xif_pkg::XIF_REG_W;

  logic [NREGS-1:0] pending_q, pending_d;
  logic             rs1_busy;
  logic             rs2_busy;
  logic             rd_busy;

  // a result in flight this cycle already frees its register
  assign rs1_busy = pending_q[rs1_i] & ~(clr_i & (clr_rd_i == rs1_i));
  assign rs2_busy = pending_q[rs2_i] & ~(clr_i & (clr_rd_i == rs2_i));
  // write-after-write also waits, one pending bit per register
  assign rd_busy  = pending_q[set_rd_i] & ~(clr_i & (clr_rd_i == set_rd_i));
  assign hazard_o = rs1_busy | rs2_busy | rd_busy;

  // clear first, a new issue to the same rd wins
  always_comb begin
    pending_d = pending_q;
    if (clr_i) begin
      pending_d[clr_rd_i] = 1'b0;
    end
    if (set_i && (set_rd_i != '0)) begin
      pending_d[set_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // dispatcher must hold back an issue until the old write has returned
  a_no_double_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_i |-> (!pending_q[set_rd_i] || (clr_i && (clr_rd_i == set_rd_i))));

endmodule

//--- xif_offload.f
source/xif_pkg.sv
source/xif_scoreboard.sv
source/xif_dispatcher.sv
source/xif_regfile.sv
source/xif_coproc.sv
source/xif_offload_top.sv
sim/tb_xif_offload.sv
